//--- sd_host.f
+incdir+verilog
verilog/sd_host_pkg.sv
verilog/sd_host_regs.sv
verilog/sd_clk_divider.sv
verilog/sd_cmd_engine.sv
verilog/sd_host_top.sv
tb/sd_card_model.sv
tb/sd_host_tb.sv

//--- run.sh
#!/bin/sh
# compile the SD host testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f sd_host.f --top-module sd_host_tb \
  --Mdir "$build_dir" -o sd_host_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$build_dir/sd_host_sim" > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "STATUS: FAIL" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

echo "simulation finished without failures"
exit 0

//--- tb/sd_host_tb.sv
// Testbench for the SD host controller with a behavioral card on the CMD line.
// Runs the SD clock at divider 1 and stops at the first mismatch.
`timescale 1ns/1ps
`include "sd_host_cfg.svh"

module sd_host_tb;

  import sd_host_pkg::*;

  localparam int ROWS = 8;
  localparam int MAX_CYCLES = ROWS * (48 + `SD_CMD_TIMEOUT + 48 + 8) * 4 + 200;

  localparam logic [2:0] FAULT_NONE   = 3'd0;
  localparam logic [2:0] FAULT_SILENT = 3'd1;
  localparam logic [2:0] FAULT_CRC    = 3'd2;
  localparam logic [2:0] FAULT_END    = 3'd3;
  localparam logic [2:0] FAULT_INDEX  = 3'd4;

  typedef struct packed {
    logic [5:0]  index;
    logic        resp;
    logic [2:0]  fault;
    logic [31:0] mask;    // INT_EN value
    logic [31:0] status;  // STATUS expected once inhibit clears
    logic        twice;   // second CMD write while busy
  } row_t;

  logic                      clk_i;
  logic                      software_reset_cmd_q;
  logic                      reg_valid;
  logic                      reg_write;
  logic [`SD_REG_ADDR_W-1:0] reg_addr;
  logic [`SD_REG_DATA_W-1:0] reg_wdata;
  logic [`SD_REG_DATA_W-1:0] reg_rdata;
  logic                      sd_clk, sd_cmd, sd_cmd_en, card_cmd, interrupt;
  logic                      card_resp_en;
  logic [2:0]                card_fault;
  sd_token_u                 card_token;
  int                        token_cnt;
  int                        cycle_cnt;
  row_t                      rows [ROWS];

  sd_host_top dut_i (
    .clk_i, .software_reset_cmd_q,
    .reg_valid_i (reg_valid), .reg_write_i (reg_write), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_rdata_o (reg_rdata),
    .sd_clk_o (sd_clk), .sd_cmd_o (sd_cmd), .sd_cmd_en_o (sd_cmd_en),
    .sd_cmd_i (card_cmd), .interrupt_o (interrupt)
  );

  sd_card_model card_i (
    .sd_clk_i (sd_clk), .cmd_i (sd_cmd), .cmd_en_i (sd_cmd_en),
    .resp_en_i (card_resp_en), .fault_i (card_fault), .cmd_o (card_cmd),
    .last_token_o (card_token), .token_cnt_o (token_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic end_in_failure();
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped on an error");
  endtask

  task automatic check_word(input string name, input logic [`SD_REG_DATA_W-1:0] got,
                            input logic [`SD_REG_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_token(input string name, input sd_token_u got, input sd_token_u exp);
    if (got.raw !== exp.raw) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got.raw, exp.raw);
      end_in_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end_in_failure();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // x^7 + x^3 + 1 over the first 40 token bits
  function automatic logic [6:0] crc7_over(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    int         i;
    crc = '0;
    for (i = 39; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], fb} ^ {3'b0, fb, 3'b0};
    end
    return crc;
  endfunction

  // both bus tasks start and end on a falling edge
  task automatic bus_write(input logic [`SD_REG_ADDR_W-1:0] addr, input logic [31:0] data);
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk_i);
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic bus_read(input logic [`SD_REG_ADDR_W-1:0] addr, output logic [31:0] data);
    reg_valid = 1'b1;
    reg_write = 1'b0;
    reg_addr  = addr;
    @(negedge clk_i);
    reg_valid = 1'b0;
    data      = reg_rdata; // loaded at the rising edge just passed
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("ERROR: no result after %0d clock cycles", MAX_CYCLES);
    end_in_failure();
  end

  initial begin
    row_t        row;
    sd_token_u   exp_tok;
    logic [31:0] rd, arg, lcg_state, resp_exp, status_left;
    int          cnt_before, r, a;
    software_reset_cmd_q = 1'b1;
    reg_valid    = 1'b0;
    reg_write    = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    card_resp_en = 1'b0;
    card_fault   = FAULT_NONE;
    lcg_state    = 32'd40;
    resp_exp     = '0;
    //          index  resp  fault         mask    status  twice
    rows[0] = '{6'd0,  1'b0, FAULT_NONE,   32'h3E, 32'h02, 1'b0};
    rows[1] = '{6'd8,  1'b1, FAULT_NONE,   32'h02, 32'h02, 1'b0};
    rows[2] = '{6'd17, 1'b1, FAULT_SILENT, 32'h04, 32'h06, 1'b0};
    rows[3] = '{6'd55, 1'b1, FAULT_CRC,    32'h08, 32'h0A, 1'b0};
    rows[4] = '{6'd13, 1'b1, FAULT_END,    32'h10, 32'h12, 1'b0};
    rows[5] = '{6'd41, 1'b1, FAULT_INDEX,  32'h20, 32'h22, 1'b0};
    rows[6] = '{6'd7,  1'b1, FAULT_NONE,   32'h3E, 32'h02, 1'b1};
    rows[7] = '{6'd2,  1'b0, FAULT_NONE,   32'h04, 32'h02, 1'b0};
    repeat (5) @(negedge clk_i);
    software_reset_cmd_q = 1'b0;

    for (a = 0; a < 6; a++) begin
      bus_read(3'(a), rd);
      check_word($sformatf("register %0d after reset", a), rd, 32'h0);
    end
    check_bit("interrupt_o", interrupt, 1'b0);
    check_bit("sd_cmd_en_o", sd_cmd_en, 1'b0);
    check_bit("sd_cmd_o", sd_cmd, 1'b1);
    check_bit("sd_clk_o", sd_clk, 1'b0);

    for (r = 0; r < ROWS; r++) begin
      row          = rows[r];
      arg          = lcg_next(lcg_state);
      lcg_state    = arg;
      card_resp_en = row.resp;
      card_fault   = row.fault;
      cnt_before   = token_cnt;
      bus_write(`SD_ADDR_CLK, 32'h101);            // divider 1, clock on
      bus_write(`SD_ADDR_INT_EN, row.mask);
      bus_write(`SD_ADDR_ARG, arg);
      bus_write(`SD_ADDR_CMD, {23'b0, row.resp, 2'b0, row.index});
      if (row.twice) bus_write(`SD_ADDR_CMD, {23'b0, 1'b0, 2'b0, ~row.index});
      do begin
        bus_read(`SD_ADDR_STATUS, rd);
      end while (rd[0]);
      check_word("STATUS", rd, row.status);
      check_bit("interrupt_o", interrupt, |(row.status[5:1] & row.mask[5:1]));

      exp_tok                = '0;
      exp_tok.fields.dir     = 1'b1;
      exp_tok.fields.index   = row.index;
      exp_tok.fields.payload = arg;
      exp_tok.fields.crc     = crc7_over(exp_tok.raw[47:8]);
      exp_tok.fields.end_bit = 1'b1;
      check_token("card token", card_token, exp_tok);
      check_word("card token count", token_cnt, cnt_before + 1);

      if (row.resp && row.fault != FAULT_SILENT) resp_exp = arg ^ 32'h5A5A5A5A;
      bus_read(`SD_ADDR_RESP, rd);
      check_word("RESP", rd, resp_exp);

      // clear complete alone first, then the rest
      status_left = row.status & ~32'h2;
      bus_write(`SD_ADDR_STATUS, 32'h2);
      bus_read(`SD_ADDR_STATUS, rd);
      check_word("STATUS", rd, status_left);
      check_bit("interrupt_o", interrupt, |(status_left[5:1] & row.mask[5:1]));
      bus_write(`SD_ADDR_STATUS, 32'h3E);
      bus_read(`SD_ADDR_STATUS, rd);
      check_word("STATUS", rd, 32'h0);
      check_bit("interrupt_o", interrupt, 1'b0);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- tb/sd_card_model.sv
// Behavioral SD card, CMD line only, one command at a time.
// Host tokens are sampled on the rising SD clock while the host drives the line.
// A reply starts 4 SD clocks after the end bit and changes on falling edges.
// fault_i: 0 none, 1 silent, 2 crc bit flipped, 3 end bit flipped, 4 wrong index.
`timescale 1ns/1ps

module sd_card_model (
  input  logic                   sd_clk_i,
  input  logic                   cmd_i,      // host to card
  input  logic                   cmd_en_i,
  input  logic                   resp_en_i,
  input  logic [2:0]             fault_i,
  output logic                   cmd_o,      // card to host, idles high
  output sd_host_pkg::sd_token_u last_token_o,
  output int                     token_cnt_o
);

  import sd_host_pkg::*;

  localparam logic [2:0] FAULT_SILENT = 3'd1;
  localparam logic [2:0] FAULT_CRC    = 3'd2;
  localparam logic [2:0] FAULT_END    = 3'd3;
  localparam logic [2:0] FAULT_INDEX  = 3'd4;

  sd_token_u rx;
  int        nbits;

  // crc7, generator 0x09, msb first
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] r;
    logic       msb;
    int         i;
    r = '0;
    for (i = 39; i >= 0; i--) begin
      msb = r[6] ^ bits[i];
      r   = {r[5:0], 1'b0} ^ (msb ? 7'h09 : 7'h00);
    end
    return r;
  endfunction

  task automatic reply(input sd_token_u cmd);
    sd_token_u rsp;
    int        i;
    rsp.raw           = '0;
    rsp.fields.start  = 1'b0;
    rsp.fields.dir    = 1'b0;                    // card to host
    rsp.fields.index  = cmd.fields.index;
    rsp.fields.payload = cmd.fields.payload ^ 32'h5A5A5A5A;
    if (fault_i == FAULT_INDEX) rsp.fields.index = ~cmd.fields.index;
    rsp.fields.crc     = crc7_of(rsp.raw[47:8]); // still valid for a wrong index
    rsp.fields.end_bit = 1'b1;
    if (fault_i == FAULT_CRC) rsp.fields.crc[0] = ~rsp.fields.crc[0];
    if (fault_i == FAULT_END) rsp.fields.end_bit = 1'b0;
    repeat (3) @(negedge sd_clk_i);
    for (i = 47; i >= 0; i--) begin
      @(negedge sd_clk_i);
      cmd_o = rsp.raw[i];
    end
    @(negedge sd_clk_i);
    cmd_o = 1'b1;
  endtask

  initial begin
    cmd_o        = 1'b1;
    rx           = '0;
    nbits        = 0;
    last_token_o = '0;
    token_cnt_o  = 0;
    forever begin
      @(posedge sd_clk_i);
      if (cmd_en_i) begin
        rx.raw = {rx.raw[46:0], cmd_i};
        nbits++;
        if (nbits == 48) begin
          nbits        = 0;
          last_token_o = rx;
          token_cnt_o++;
          if (resp_en_i && fault_i != FAULT_SILENT) reply(rx);
        end
      end
    end
  end

endmodule

//--- verilog/sd_host_top.sv
// Top level of the cut-down SD host controller, CMD line only.
// There are no DAT lines, no card detect and no write protect.
// The driver is expected to enable the SD clock before issuing a command.
`timescale 1ns/1ps
`include "sd_host_cfg.svh"

module sd_host_top (
  input  logic                      clk_i,
  input  logic                      software_reset_cmd_q,
  input  logic                      reg_valid_i,
  input  logic                      reg_write_i,
  input  logic [`SD_REG_ADDR_W-1:0] reg_addr_i,
  input  logic [`SD_REG_DATA_W-1:0] reg_wdata_i,
  output logic [`SD_REG_DATA_W-1:0] reg_rdata_o,
  output logic                      sd_clk_o,
  output logic                      sd_cmd_o,
  output logic                      sd_cmd_en_o,
  input  logic                      sd_cmd_i,
  output logic                      interrupt_o
);

  import sd_host_pkg::*;

  sd_token_u  cmd_token, resp_token;
  logic       cmd_start, resp_expected, cmd_done;
  logic       err_timeout, err_crc, err_end, err_index;
  logic [7:0] clk_div;
  logic       clk_en, sd_clk_en_p, sd_clk_en_n;

  sd_host_regs i_regs (
    .clk_i,
    .software_reset_cmd_q,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .cmd_done_i      (cmd_done),
    .resp_token_i    (resp_token),
    .err_timeout_i   (err_timeout),
    .err_crc_i       (err_crc),
    .err_end_i       (err_end),
    .err_index_i     (err_index),
    .cmd_start_o     (cmd_start),
    .cmd_token_o     (cmd_token),
    .resp_expected_o (resp_expected),
    .clk_div_o       (clk_div),
    .clk_en_o        (clk_en),
    .interrupt_o
  );

  sd_clk_divider i_sd_clk_divider (
    .clk_i,
    .software_reset_cmd_q,
    .clk_div_i  (clk_div),
    .clk_en_i   (clk_en),
    .sd_clk_o,
    .clk_en_p_o (sd_clk_en_p),
    .clk_en_n_o (sd_clk_en_n)
  );

  sd_cmd_engine i_cmd_engine (
    .clk_i,
    .software_reset_cmd_q,
    .clk_en_p_i      (sd_clk_en_p),
    .clk_en_n_i      (sd_clk_en_n),
    .cmd_start_i     (cmd_start),
    .cmd_token_i     (cmd_token),
    .resp_expected_i (resp_expected),
    .sd_cmd_i,
    .sd_cmd_o,
    .sd_cmd_en_o,
    .cmd_done_o      (cmd_done),
    .resp_token_o    (resp_token),
    .err_timeout_o   (err_timeout),
    .err_crc_o       (err_crc),
    .err_end_o       (err_end),
    .err_index_o     (err_index)
  );

endmodule

//--- verilog/sd_cmd_engine.sv
// CMD line engine of the SD host controller.
// Sends a 48-bit command on falling edge strobes and inserts its CRC7.
// With a response expected it samples a 48-bit short response on rising edge
// strobes. No start bit within SD_CMD_TIMEOUT strobes ends in a timeout.
// All line activity follows the strobes, so a stopped SD clock stalls it.
`timescale 1ns/1ps
`include "sd_host_cfg.svh"

module sd_cmd_engine (
  input  logic                   clk_i,
  input  logic                   software_reset_cmd_q,
  input  logic                   clk_en_p_i,
  input  logic                   clk_en_n_i,
  input  logic                   cmd_start_i,
  input  sd_host_pkg::sd_token_u cmd_token_i,
  input  logic                   resp_expected_i,
  input  logic                   sd_cmd_i,
  output logic                   sd_cmd_o,
  output logic                   sd_cmd_en_o,
  output logic                   cmd_done_o,
  output sd_host_pkg::sd_token_u resp_token_o,
  output logic                   err_timeout_o,
  output logic                   err_crc_o,
  output logic                   err_end_o,
  output logic                   err_index_o
);

  import sd_host_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT,  // waiting for the response start bit
    ST_RECV,
    ST_DONE
  } state_e;

  state_e     state_q;
  sd_token_u  tok_q;        // shared tx and rx shift word
  logic [5:0] index_q;      // index sent, to compare against the response
  logic [5:0] bit_cnt_q;
  logic [7:0] tmo_q;
  logic [6:0] crc_q;
  logic       cmd_out_q;
  logic       cmd_en_q;
  logic       resp_exp_q;
  logic       timeout_q;
  logic       rx_q;         // a full response was taken

  logic start_cmd;
  logic send_bit;
  logic rx_bit;
  logic tx_bit;

  // crc7 with polynomial x^7 + x^3 + 1
  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
    logic fb;
    fb = din ^ crc[6];
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

  assign start_cmd = (state_q == ST_IDLE) & cmd_start_i;
  assign send_bit  = (state_q == ST_SEND) & clk_en_n_i & (bit_cnt_q < 6'd48);
  assign rx_bit    = clk_en_p_i & (((state_q == ST_WAIT) & ~sd_cmd_i) | (state_q == ST_RECV));
  assign tx_bit    = (bit_cnt_q >= 6'd40 && bit_cnt_q < 6'd47) ? crc_q[6] : tok_q.raw[47];

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      state_q    <= ST_IDLE;
      bit_cnt_q  <= '0;
      tmo_q      <= '0;
      crc_q      <= '0;
      cmd_out_q  <= 1'b1;
      cmd_en_q   <= 1'b0;
      resp_exp_q <= 1'b0;
      timeout_q  <= 1'b0;
      rx_q       <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_start_i) begin
            resp_exp_q <= resp_expected_i;
            bit_cnt_q  <= '0;
            crc_q      <= '0;
            timeout_q  <= 1'b0;
            rx_q       <= 1'b0;
            state_q    <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (clk_en_n_i) begin
            if (bit_cnt_q == 6'd48) begin // end bit has been on the line a full period
              cmd_en_q  <= 1'b0;
              cmd_out_q <= 1'b1;
              bit_cnt_q <= '0;
              crc_q     <= '0;
              tmo_q     <= '0;
              state_q   <= resp_exp_q ? ST_WAIT : ST_DONE;
            end else begin
              cmd_en_q  <= 1'b1;
              cmd_out_q <= tx_bit;
              bit_cnt_q <= bit_cnt_q + 6'd1;
              if (bit_cnt_q < 6'd40) crc_q <= crc7_next(crc_q, tx_bit);
              else                   crc_q <= {crc_q[5:0], 1'b0};
            end
          end
        end
        ST_WAIT: begin
          if (clk_en_p_i) begin
            if (!sd_cmd_i) begin
              bit_cnt_q <= 6'd1;
              crc_q     <= crc7_next(crc_q, 1'b0);
              state_q   <= ST_RECV;
            end else if (tmo_q == 8'(`SD_CMD_TIMEOUT - 1)) begin
              timeout_q <= 1'b1;
              state_q   <= ST_DONE;
            end else begin
              tmo_q <= tmo_q + 8'd1;
            end
          end
        end
        ST_RECV: begin
          if (clk_en_p_i) begin
            bit_cnt_q <= bit_cnt_q + 6'd1;
            if (bit_cnt_q < 6'd40) crc_q <= crc7_next(crc_q, sd_cmd_i);
            if (bit_cnt_q == 6'd47) begin
              rx_q    <= 1'b1;
              state_q <= ST_DONE;
            end
          end
        end
        default: state_q <= ST_IDLE; // ST_DONE lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_cmd) begin
      tok_q   <= cmd_token_i;
      index_q <= cmd_token_i.fields.index;
    end else if (send_bit) begin
      tok_q.raw <= {tok_q.raw[46:0], 1'b1};
    end else if (rx_bit) begin
      tok_q.raw <= {tok_q.raw[46:0], sd_cmd_i};
    end
  end

  assign sd_cmd_o      = cmd_out_q;
  assign sd_cmd_en_o   = cmd_en_q;
  assign cmd_done_o    = (state_q == ST_DONE);
  assign resp_token_o  = tok_q;
  assign err_timeout_o = cmd_done_o & timeout_q;
  assign err_crc_o     = cmd_done_o & rx_q & (tok_q.fields.crc != crc_q);
  assign err_end_o     = cmd_done_o & rx_q & ~tok_q.fields.end_bit;
  assign err_index_o   = cmd_done_o & rx_q & (tok_q.fields.index != index_q);

  a_released_in_rx: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    (state_q inside {ST_WAIT, ST_RECV}) |-> !sd_cmd_en_o);

  a_done_pulse: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    cmd_done_o |=> !cmd_done_o);

endmodule

//--- verilog/sd_clk_divider.sv
// SD clock generator with edge strobes in the system clock domain.
// sd_clk_o toggles every clk_div_i+1 cycles and stays low while disabled.
// Each strobe is high in the first cycle of the new clock level.
`timescale 1ns/1ps

module sd_clk_divider (
  input  logic       clk_i,
  input  logic       software_reset_cmd_q,
  input  logic [7:0] clk_div_i,
  input  logic       clk_en_i,
  output logic       sd_clk_o,
  output logic       clk_en_p_o,
  output logic       clk_en_n_o
);

  logic [7:0] cnt_q;
  logic       sd_clk_q;
  logic       en_p_q;
  logic       en_n_q;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cnt_q    <= '0;
      sd_clk_q <= 1'b0;
      en_p_q   <= 1'b0;
      en_n_q   <= 1'b0;
    end else if (!clk_en_i) begin
      cnt_q    <= '0;   // park low, the engine just waits
      sd_clk_q <= 1'b0;
      en_p_q   <= 1'b0;
      en_n_q   <= 1'b0;
    end else begin
      en_p_q <= 1'b0;
      en_n_q <= 1'b0;
      if (cnt_q >= clk_div_i) begin // >= also covers a divider lowered mid count
        cnt_q    <= '0;
        sd_clk_q <= ~sd_clk_q;
        en_p_q   <= ~sd_clk_q;
        en_n_q   <= sd_clk_q;
      end else begin
        cnt_q <= cnt_q + 8'd1;
      end
    end
  end

  assign sd_clk_o   = sd_clk_q;
  assign clk_en_p_o = en_p_q;
  assign clk_en_n_o = en_n_q;

  a_one_edge: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    !(clk_en_p_o && clk_en_n_o));

endmodule

//--- verilog/sd_host_regs.sv
// Software visible registers of the SD host controller.
// Reads return the addressed word in the cycle after the request.
// STATUS bits 5:1 are write-1-to-clear and a hardware set in the same cycle wins.
// A CMD write while the command inhibit bit is set is dropped.
`timescale 1ns/1ps
`include "sd_host_cfg.svh"

module sd_host_regs (
  input  logic                      clk_i,
  input  logic                      software_reset_cmd_q,
  input  logic                      reg_valid_i,
  input  logic                      reg_write_i,
  input  logic [`SD_REG_ADDR_W-1:0] reg_addr_i,
  input  logic [`SD_REG_DATA_W-1:0] reg_wdata_i,
  output logic [`SD_REG_DATA_W-1:0] reg_rdata_o,
  input  logic                      cmd_done_i,
  input  sd_host_pkg::sd_token_u    resp_token_i,
  input  logic                      err_timeout_i,
  input  logic                      err_crc_i,
  input  logic                      err_end_i,
  input  logic                      err_index_i,
  output logic                      cmd_start_o,
  output sd_host_pkg::sd_token_u    cmd_token_o,
  output logic                      resp_expected_o,
  output logic [7:0]                clk_div_o,
  output logic                      clk_en_o,
  output logic                      interrupt_o
);

  logic [31:0] arg_q;
  logic [5:0]  cmd_index_q;
  logic        cmd_resp_q;     // response expected for the current command
  logic [31:0] resp_q;
  logic        inhibit_q;
  logic [5:1]  status_q;       // 5 index, 4 end, 3 crc, 2 timeout, 1 complete
  logic [7:0]  clk_div_q;
  logic        clk_en_q;
  logic [5:1]  int_en_q;
  logic        cmd_start_q;
  logic [`SD_REG_DATA_W-1:0] rdata_q;
  logic [`SD_REG_DATA_W-1:0] rd_word;

  logic wr_en, wr_arg, wr_cmd, wr_status, wr_clk, wr_int_en;
  logic launch;
  logic [5:1] w1c_mask;
  logic [5:1] hw_set;

  assign wr_en     = reg_valid_i & reg_write_i;
  assign wr_arg    = wr_en & (reg_addr_i == `SD_ADDR_ARG);
  assign wr_cmd    = wr_en & (reg_addr_i == `SD_ADDR_CMD);
  assign wr_status = wr_en & (reg_addr_i == `SD_ADDR_STATUS);
  assign wr_clk    = wr_en & (reg_addr_i == `SD_ADDR_CLK);
  assign wr_int_en = wr_en & (reg_addr_i == `SD_ADDR_INT_EN);
  assign launch    = wr_cmd & ~inhibit_q; // the only place inhibit guards a start

  assign w1c_mask = wr_status ? reg_wdata_i[5:1] : 5'b0;
  assign hw_set   = cmd_done_i ? {err_index_i, err_end_i, err_crc_i, err_timeout_i, 1'b1}
                               : 5'b0;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      arg_q       <= '0;
      cmd_index_q <= '0;
      cmd_resp_q  <= 1'b0;
      resp_q      <= '0;
      inhibit_q   <= 1'b0;
      status_q    <= '0;
      clk_div_q   <= '0;
      clk_en_q    <= 1'b0;
      int_en_q    <= '0;
      cmd_start_q <= 1'b0;
    end else begin
      cmd_start_q <= launch;
      if (wr_arg) arg_q <= reg_wdata_i;
      if (launch) begin
        cmd_index_q <= reg_wdata_i[5:0];
        cmd_resp_q  <= reg_wdata_i[8];
        inhibit_q   <= 1'b1;
      end else if (cmd_done_i) begin
        inhibit_q <= 1'b0;
      end
      // response is kept unless one was actually received
      if (cmd_done_i && cmd_resp_q && !err_timeout_i) begin
        resp_q <= resp_token_i.fields.payload;
      end
      status_q <= (status_q & ~w1c_mask) | hw_set;
      if (wr_clk) begin
        clk_div_q <= reg_wdata_i[7:0];
        clk_en_q  <= reg_wdata_i[8];
      end
      if (wr_int_en) int_en_q <= reg_wdata_i[5:1];
    end
  end

  always_comb begin
    rd_word = '0;
    case (reg_addr_i)
      `SD_ADDR_ARG:    rd_word = arg_q;
      `SD_ADDR_CMD:    rd_word = {23'b0, cmd_resp_q, 2'b0, cmd_index_q};
      `SD_ADDR_RESP:   rd_word = resp_q;
      `SD_ADDR_STATUS: rd_word = {26'b0, status_q, inhibit_q};
      `SD_ADDR_CLK:    rd_word = {23'b0, clk_en_q, clk_div_q};
      `SD_ADDR_INT_EN: rd_word = {26'b0, int_en_q, 1'b0};
      default:         rd_word = '0;
    endcase
  end

  // read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      rdata_q <= '0;
    end else if (reg_valid_i && !reg_write_i) begin
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    cmd_token_o                = '0;
    cmd_token_o.fields.start   = 1'b0;
    cmd_token_o.fields.dir     = 1'b1;        // host to card
    cmd_token_o.fields.index   = cmd_index_q;
    cmd_token_o.fields.payload = arg_q;
    cmd_token_o.fields.end_bit = 1'b1;        // crc is filled in by the engine
  end

  assign reg_rdata_o     = rdata_q;
  assign cmd_start_o     = cmd_start_q;
  assign resp_expected_o = cmd_resp_q;
  assign clk_div_o       = clk_div_q;
  assign clk_en_o        = clk_en_q;
  assign interrupt_o     = |(status_q & int_en_q);

  // a start only ever follows a cycle with the command line free
  a_start_not_inhibited: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    cmd_start_o |-> !$past(inhibit_q));

  // the engine reports completion only for a command that was launched here
  a_done_while_busy: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    cmd_done_i |-> inhibit_q);

endmodule

//--- verilog/sd_host_pkg.sv
// Types shared by the SD host controller blocks.
// A command and a short response share the same 48-bit layout on the CMD line,
// sent and received MSB first.
package sd_host_pkg;

  // field view of a token, most significant bit goes out first
  typedef struct packed {
    logic       start;   // always 0 on the line
    logic       dir;     // 1 host to card, 0 card to host
    logic [5:0] index;
    logic [31:0] payload; // argument or card status
    logic [6:0] crc;     // crc7 over the 40 bits above
    logic       end_bit; // always 1 on the line
  } sd_token_fields_t;

  // one token word seen either as a shift word or as its fields
  typedef union packed {
    logic [47:0]      raw;
    sd_token_fields_t fields;
  } sd_token_u;

endpackage

//--- verilog/sd_host_cfg.svh
// Build constants of the SD host controller.
// The register bus is word addressed, so the addresses are word indices.
// SD_CMD_TIMEOUT counts SD clock periods and must fit in 8 bits.
`ifndef SD_HOST_CFG_SVH
`define SD_HOST_CFG_SVH

`define SD_REG_ADDR_W 3
`define SD_REG_DATA_W 32

// register word addresses
`define SD_ADDR_ARG    3'd0
`define SD_ADDR_CMD    3'd1
`define SD_ADDR_RESP   3'd2
`define SD_ADDR_STATUS 3'd3
`define SD_ADDR_CLK    3'd4
`define SD_ADDR_INT_EN 3'd5

`define SD_CMD_TIMEOUT 64 // sd clock periods until the response start bit

`endif
